// ==== verilog/fma16_pkg.sv ====
/*
 * fma16 datapath definitions
 * half-precision word format, width of the centered sum vector and the
 * structs that carry operands, aligned sums and rounded results
 */
package fma16_pkg;

    localparam int EXP_BIAS = 15;
    // extra low positions below the product field, bit 0 doubles as the sticky jam
    localparam int END_BITS = 8;
    // ten guard bits above a 22-bit product and END_BITS below it
    localparam int VEC_SIZE = 10 + 22 + END_BITS - 1;
    // hidden-bit position of a normalized sum, the product binary point
    localparam int HIDDEN_POS = END_BITS + 20;
    // largest upward shift of the addend before the anchor moves onto it
    localparam logic signed [6:0] MAX_ALIGN = 7'sd10;

    typedef logic [VEC_SIZE:0] vec_t;

    typedef struct packed {
        logic       sign;
        logic [4:0] exp;
        logic [9:0] frac;
    } half_fields_t;

    // the same word seen as raw bits or as its three fields
    typedef union packed {
        logic [15:0]  raw;
        half_fields_t f;
    } half_t;

    typedef struct packed {
        half_t x;
        half_t y;
        half_t z;
    } fma_operands_t;

    typedef struct packed {
        vec_t              sm;
        logic signed [6:0] a_cnt;
        logic              diff_sign;
        logic              res_sign;
        logic signed [6:0] pe;
        // bit 1 marks a zero product, bit 0 a zero addend
        logic [1:0]        zero_flags;
    } align_out_t;

    typedef struct packed {
        half_t result;
        logic  overflow;
        logic  inexact;
    } fma_result_t;

endpackage

// ==== verilog/fma16_apb_pkg.sv ====
/*
 * fma16 APB register map
 * bus request and response structs, register offsets and status bits
 */
package fma16_apb_pkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
        logic        pslverr;
    } apb_rsp_t;

    localparam logic [7:0] REG_X      = 8'h00;
    localparam logic [7:0] REG_Y      = 8'h04;
    localparam logic [7:0] REG_Z      = 8'h08;
    localparam logic [7:0] REG_CTRL   = 8'h0C;
    localparam logic [7:0] REG_RESULT = 8'h10;
    localparam logic [7:0] REG_STATUS = 8'h14;

    localparam int STAT_DONE    = 0;
    localparam int STAT_OVF     = 1;
    localparam int STAT_INEXACT = 2;

endpackage

// ==== verilog/fma16_align.sv ====
/*
 * fma16 alignment stage
 * multiplies the mantissas, aligns the addend against the product on a
 * centered vector and adds or subtracts them, larger magnitude on top
 */
module fma16_align
    import fma16_pkg::*;
(
    input  fma_operands_t ops,
    output align_out_t    al
);

    logic              x_zero, y_zero, p_zero, z_zero;
    logic [10:0]       mx, my, mz;
    logic [21:0]       pm;
    logic              p_sign, eff_sub;
    logic signed [6:0] pe_raw, a_raw;
    vec_t              p_vec, z_vec, p_al, z_al;

    // right shift that ORs every bit falling off the end into bit 0
    function automatic vec_t shr_jam(input vec_t v, input logic [6:0] n);
        vec_t lost;
        lost = v & ~(vec_t'('1) << n);
        return (v >> n) | vec_t'(|lost);
    endfunction

    // exponent zero means a zero operand, subnormals are not supported
    assign x_zero = (ops.x.f.exp == 5'd0);
    assign y_zero = (ops.y.f.exp == 5'd0);
    assign z_zero = (ops.z.f.exp == 5'd0);
    assign p_zero = x_zero | y_zero;

    assign mx = x_zero ? 11'd0 : {1'b1, ops.x.f.frac};
    assign my = y_zero ? 11'd0 : {1'b1, ops.y.f.frac};
    assign mz = z_zero ? 11'd0 : {1'b1, ops.z.f.frac};
    assign pm = mx * my;

    assign p_sign = ops.x.f.sign ^ ops.y.f.sign;
    assign pe_raw = 7'(ops.x.f.exp) + 7'(ops.y.f.exp) - 7'(EXP_BIAS);
    assign a_raw  = 7'(ops.z.f.exp) - pe_raw;
    assign eff_sub = (p_sign ^ ops.z.f.sign) & ~p_zero & ~z_zero;

    // product binary point and addend hidden bit both start at HIDDEN_POS
    assign p_vec = vec_t'(pm) << END_BITS;
    assign z_vec = vec_t'(mz) << (HIDDEN_POS - 10);

    always_comb begin
        p_al = p_vec;
        z_al = z_vec;
        al.a_cnt = a_raw;
        al.pe = pe_raw;
        if (p_zero) begin
            // the addend alone sits at the binary point with its own exponent
            p_al = '0;
            al.a_cnt = '0;
            al.pe = 7'(ops.z.f.exp);
        end else if (z_zero) begin
            z_al = '0;
            al.a_cnt = '0;
        end else if (a_raw > MAX_ALIGN) begin
            // addend far above the product, so the anchor moves up to it
            // and the product slides down into the sticky region
            al.a_cnt = MAX_ALIGN;
            al.pe = 7'(ops.z.f.exp) - MAX_ALIGN;
            p_al = shr_jam(p_vec, a_raw - MAX_ALIGN);
            z_al = z_vec << MAX_ALIGN;
        end else if (!a_raw[6]) begin
            z_al = z_vec << a_raw;
        end else begin
            z_al = shr_jam(z_vec, -a_raw);
        end

        al.diff_sign = eff_sub;
        if (eff_sub && (z_al > p_al)) begin
            al.sm = z_al - p_al;
            al.res_sign = ops.z.f.sign;
        end else if (eff_sub) begin
            al.sm = p_al - z_al;
            al.res_sign = p_sign;
        end else begin
            al.sm = z_al + p_al;
            al.res_sign = p_zero ? ops.z.f.sign : p_sign;
        end
        al.zero_flags = {p_zero, z_zero};
    end

endmodule

// ==== verilog/fma16_mshifter.sv ====
/*
 * fma16 leading-one shift predictor
 * returns the signed left shift that puts the leading one of the sum on
 * the hidden-bit position, searching only where the one can land
 */
module fma16_mshifter
    import fma16_pkg::*;
(
    input  vec_t              sm,
    input  logic signed [6:0] a_cnt,
    input  logic              diff_sign,
    output logic signed [7:0] m_shift
);

    logic signed [7:0] a_ext;
    logic signed [7:0] enc_shift;

    assign a_ext = {a_cnt[6], a_cnt};

    // full priority encoder over the sum, the highest set bit wins
    always_comb begin
        enc_shift = '0;
        for (int i = 0; i <= VEC_SIZE; i++) begin
            if (sm[i]) begin
                enc_shift = 8'(HIDDEN_POS - i);
            end
        end
    end

    always_comb begin
        m_shift = '0;
        if (sm == '0) begin
            // a zero sum needs no shift
            m_shift = '0;
        end else if (diff_sign) begin
            if (a_cnt > 7'sd2) begin
                // addend dominates, at most its top bit is lost to the borrow
                if (sm[HIDDEN_POS + a_cnt])          m_shift = -a_ext;
                else if (sm[HIDDEN_POS + a_cnt - 1]) m_shift = 8'sd1 - a_ext;
            end else if (a_cnt < -7'sd1) begin
                // product dominates, the difference stays within one bit of the point
                if (sm[HIDDEN_POS + 1])      m_shift = -8'sd1;
                else if (sm[HIDDEN_POS])     m_shift = 8'sd0;
                else if (sm[HIDDEN_POS - 1]) m_shift = 8'sd1;
            end else begin
                // close exponents can cancel any number of bits
                m_shift = enc_shift;
            end
        end else begin
            if (a_cnt > 7'sd0) begin
                // the addend is on top and the carry can add one bit
                if (sm[HIDDEN_POS + a_cnt + 1]) m_shift = -8'sd1 - a_ext;
                else if (sm[HIDDEN_POS + a_cnt]) m_shift = -a_ext;
            end else begin
                // the product is on top, the sum lies between 1 and 6
                if (sm[HIDDEN_POS + 2])      m_shift = -8'sd2;
                else if (sm[HIDDEN_POS + 1]) m_shift = -8'sd1;
                else if (sm[HIDDEN_POS])     m_shift = 8'sd0;
            end
        end
    end

endmodule

// ==== verilog/fma16_normround.sv ====
/*
 * fma16 normalize and round stage
 * shifts the sum by the predicted amount, rounds to nearest even and packs
 * the half-precision result with its overflow and inexact flags
 */
module fma16_normround
    import fma16_pkg::*;
(
    input  align_out_t        al,
    input  logic signed [7:0] m_shift,
    output fma_result_t       res
);

    localparam int MAX_EXP = 2 * EXP_BIAS;

    logic [2*VEC_SIZE+1:0] wide;
    vec_t                  norm;
    logic                  lo_sticky, zero_sum;
    logic [10:0]           mant;
    logic                  guard, rnd, sticky, round_up;
    logic [11:0]           mant_rnd;
    logic signed [9:0]     exp_norm, exp_rnd;

    // the lower half catches whatever a right shift pushes out
    always_comb begin
        if (m_shift[7]) begin
            wide = {al.sm, {(VEC_SIZE + 1){1'b0}}} >> (-m_shift);
        end else begin
            wide = {al.sm, {(VEC_SIZE + 1){1'b0}}} << m_shift;
        end
    end

    assign norm      = wide[2*VEC_SIZE+1 -: VEC_SIZE+1];
    assign lo_sticky = |wide[VEC_SIZE:0];
    assign zero_sum  = (al.sm == '0) || (&al.zero_flags);

    // eleven kept bits, then guard and round, everything lower is sticky
    assign mant     = norm[HIDDEN_POS -: 11];
    assign guard    = norm[HIDDEN_POS - 11];
    assign rnd      = norm[HIDDEN_POS - 12];
    assign sticky   = (|norm[HIDDEN_POS - 13:0]) | lo_sticky;
    assign round_up = guard & (rnd | sticky | mant[0]);
    assign mant_rnd = {1'b0, mant} + 12'(round_up);

    // a mantissa carry out of rounding bumps the exponent by one
    assign exp_norm = {{3{al.pe[6]}}, al.pe} - {{2{m_shift[7]}}, m_shift};
    assign exp_rnd  = exp_norm + 10'(mant_rnd[11]);

    always_comb begin
        res.overflow = 1'b0;
        res.inexact = ~zero_sum & (guard | rnd | sticky);
        res.result.f.sign = al.res_sign;
        res.result.f.exp = exp_rnd[4:0];
        res.result.f.frac = mant_rnd[11] ? mant_rnd[10:1] : mant_rnd[9:0];
        if (zero_sum) begin
            // exact cancellation and zero operands give plus zero
            res.result.raw = '0;
        end else if (exp_rnd > MAX_EXP) begin
            res.overflow = 1'b1;
            res.result.f.exp = 5'h1f;
            res.result.f.frac = '0;
        end else if (exp_rnd < 1) begin
            // underflow flushes to zero and keeps the sign
            res.result.f.exp = '0;
            res.result.f.frac = '0;
        end
    end

endmodule

// ==== verilog/fma16_regs.sv ====
/*
 * fma16 APB register block
 * holds the operands, launches the datapath on a start write and latches
 * the result two edges later together with its status flags
 */
module fma16_regs
    import fma16_pkg::*;
    import fma16_apb_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  apb_req_t      req,
    output apb_rsp_t      rsp,
    output fma_operands_t ops,
    input  fma_result_t   res
);

    logic        access, addr_ok, ro_hit, slverr, wr_ok, start;
    logic        busy, done;
    logic [31:0] rdata;
    fma_result_t res_q;

    // decode in the access cycle only, there are no wait states
    assign access = req.psel & req.penable;
    assign ro_hit = (req.paddr == REG_RESULT) || (req.paddr == REG_STATUS);
    assign slverr = access & (~addr_ok | (req.pwrite & ro_hit));
    assign wr_ok  = access & req.pwrite & ~slverr;
    assign start  = wr_ok & (req.paddr == REG_CTRL) & req.pwdata[0];

    always_comb begin
        addr_ok = 1'b1;
        rdata = '0;
        case (req.paddr)
            REG_X:      rdata = {16'd0, ops.x.raw};
            REG_Y:      rdata = {16'd0, ops.y.raw};
            REG_Z:      rdata = {16'd0, ops.z.raw};
            REG_CTRL:   rdata = {31'd0, busy};
            REG_RESULT: rdata = {16'd0, res_q.result.raw};
            REG_STATUS: begin
                rdata[STAT_DONE] = done;
                rdata[STAT_OVF] = res_q.overflow;
                rdata[STAT_INEXACT] = res_q.inexact;
            end
            default:    addr_ok = 1'b0;
        endcase
    end

    assign rsp = '{pready: 1'b1,
                   prdata: (access & ~req.pwrite & addr_ok) ? rdata : 32'd0,
                   pslverr: slverr};

    always_ff @(posedge clk) begin
        if (rst) begin
            ops <= '0;
            busy <= 1'b0;
            done <= 1'b0;
            res_q <= '0;
        end else begin
            if (wr_ok && req.paddr == REG_X) ops.x.raw <= req.pwdata[15:0];
            if (wr_ok && req.paddr == REG_Y) ops.y.raw <= req.pwdata[15:0];
            if (wr_ok && req.paddr == REG_Z) ops.z.raw <= req.pwdata[15:0];
            // a start during busy simply restarts the pipeline bit
            if (start) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (busy) begin
                busy <= 1'b0;
                done <= 1'b1;
                res_q <= res;
            end
        end
    end

endmodule

// ==== verilog/fma16_apb.sv ====
/*
 * fma16 APB peripheral top level
 * register block feeding the align, shift-predict and round stages
 */
module fma16_apb
    import fma16_pkg::*;
    import fma16_apb_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  apb_req_t req,
    output apb_rsp_t rsp
);

    fma_operands_t     ops;
    align_out_t        al;
    logic signed [7:0] m_shift;
    fma_result_t       res;

    fma16_regs i_regs (.clk(clk), .rst(rst), .req(req), .rsp(rsp), .ops(ops), .res(res));

    fma16_align i_align (.ops(ops), .al(al));

    // the predictor sees only the sum, the gap and the operation
    fma16_mshifter i_mshifter (
        .sm(al.sm), .a_cnt(al.a_cnt), .diff_sign(al.diff_sign), .m_shift(m_shift)
    );

    fma16_normround i_normround (.al(al), .m_shift(m_shift), .res(res));

endmodule

// ==== test/fma16_checker.sv ====
/*
 * fma16 APB checker
 * models the register map and the start to done timing, computes the exact
 * fused multiply-add with one round to nearest even, compares every access
 */
module fma16_checker
    import fma16_pkg::*;
    import fma16_apb_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  apb_req_t req,
    input  apb_rsp_t rsp,
    input  int       test_id,
    output int       errors
);
    timeunit 1ns;
    timeprecision 1ps;

    half_t       x_q, y_q, z_q;
    logic        pend, done, access, known, bad, wr, start;
    logic [31:0] exp_data;
    fma_result_t exp_res;

    // exact x*y+z as an integer scaled by 2^48, then rounded to eleven significant bits
    function automatic fma_result_t fma_ref(input half_t x, input half_t y, input half_t z);
        logic [127:0] p, q, m, rem, half;
        logic         ps, s;
        logic [11:0]  mant;
        int           sh, lead, e;
        p = '0;
        q = '0;
        lead = 0;
        if (x.f.exp != 0 && y.f.exp != 0) begin
            sh = x.f.exp + y.f.exp - 2;
            p = {1'b1, x.f.frac};
            p = (p * {1'b1, y.f.frac}) << sh;
        end
        if (z.f.exp != 0) begin
            sh = z.f.exp + 23;
            q = {1'b1, z.f.frac};
            q = q << sh;
        end
        ps = x.f.sign ^ y.f.sign;
        if (ps == z.f.sign) begin
            m = p + q;
            s = ps;
        end else if (p >= q) begin
            m = p - q;
            s = ps;
        end else begin
            m = q - p;
            s = z.f.sign;
        end
        // exact zero is always plus zero
        if (m == '0) return '0;
        for (int i = 0; i < 128; i++) begin
            if (m[i]) lead = i;
        end
        e = lead - 33;
        sh = (lead > 10) ? lead - 10 : 0;
        if (lead >= 10) mant = 12'(m >> sh);
        else mant = 12'(m << (10 - lead));
        rem = m & ((128'd1 << sh) - 128'd1);
        half = (128'd1 << sh) >> 1;
        if (rem > half || (rem == half && rem != '0 && mant[0])) mant++;
        if (mant[11]) begin
            mant = mant >> 1;
            e++;
        end
        if (e > 30) return {s, 5'h1f, 10'd0, 1'b1, rem != '0};
        if (e < 1) return {s, 15'd0, 1'b0, rem != '0};
        return {s, 5'(e), mant[9:0], 1'b0, rem != '0};
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1: return "register_access";
            2: return "exact_results";
            3: return "cancellation";
            4: return "exponent_gaps";
            5: return "overflow_underflow";
            default: return "random_operands";
        endcase
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("Error %s: %s at offset %h expected %h actual %h",
                 test_name(test_id), what, req.paddr, expected, actual);
    endtask

    assign access = req.psel & req.penable;
    assign bad = !known || (req.pwrite && (req.paddr == REG_RESULT || req.paddr == REG_STATUS));
    assign wr = access & req.pwrite & ~bad;
    assign start = wr && req.paddr == REG_CTRL && req.pwdata[0];

    // what a read of the addressed register must return
    always_comb begin
        known = 1'b1;
        exp_data = '0;
        case (req.paddr)
            REG_X:      exp_data = {16'd0, x_q.raw};
            REG_Y:      exp_data = {16'd0, y_q.raw};
            REG_Z:      exp_data = {16'd0, z_q.raw};
            REG_CTRL:   exp_data = {31'd0, pend};
            REG_RESULT: exp_data = {16'd0, exp_res.result.raw};
            REG_STATUS: begin
                exp_data[STAT_DONE] = done;
                exp_data[STAT_OVF] = exp_res.overflow;
                exp_data[STAT_INEXACT] = exp_res.inexact;
            end
            default:    known = 1'b0;
        endcase
    end

    initial errors = 0;

    // the model follows the bus on the same edges as the register block
    always @(posedge clk) begin
        if (rst) begin
            x_q <= '0;
            y_q <= '0;
            z_q <= '0;
            pend <= 1'b0;
            done <= 1'b0;
            exp_res <= '0;
        end else begin
            if (wr && req.paddr == REG_X) x_q.raw <= req.pwdata[15:0];
            if (wr && req.paddr == REG_Y) y_q.raw <= req.pwdata[15:0];
            if (wr && req.paddr == REG_Z) z_q.raw <= req.pwdata[15:0];
            if (start) begin
                pend <= 1'b1;
                done <= 1'b0;
            end else if (pend) begin
                pend <= 1'b0;
                done <= 1'b1;
                exp_res <= fma_ref(x_q, y_q, z_q);
            end
        end
    end

    // the response is stable by the falling edge of the access cycle
    always @(negedge clk) begin
        if (!rst && access) begin
            if (rsp.pready !== 1'b1) begin
                errors++;
                $display("pready was low during an access to offset %h", req.paddr);
            end
            if (rsp.pslverr !== bad) begin
                report_mismatch("pslverr", 32'(bad), 32'(rsp.pslverr));
            end else if (!req.pwrite && !bad && rsp.prdata !== exp_data) begin
                report_mismatch("read data", exp_data, rsp.prdata);
            end
        end
    end

endmodule

// ==== test/tb_fma16.sv ====
/*
 * fma16 APB peripheral testbench
 * register access, directed rounding cases and random operands over APB,
 * with the checker comparing every access against its model
 */
module tb_fma16
    import fma16_apb_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_DIRECTED = 22;
    localparam int NUM_RANDOM = 300;
    // forty cycles per operation, the rest covers reset and the register test
    localparam int CYCLE_LIMIT = 40 * (NUM_DIRECTED + NUM_RANDOM) + 200;

    logic        clk;
    logic        rst;
    apb_req_t    req;
    apb_rsp_t    rsp;
    int          test_id;
    int          errors;
    int          cycles;
    logic [31:0] rdata;

    fma16_apb i_fma16_apb (.clk(clk), .rst(rst), .req(req), .rsp(rsp));

    fma16_checker i_checker (
        .clk(clk), .rst(rst), .req(req), .rsp(rsp), .test_id(test_id), .errors(errors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // setup cycle, access cycle, then the bus goes idle again
    task automatic apb_transfer(input logic wr, input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        #2;
        req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: data};
        @(posedge clk);
        #2;
        req.penable = 1'b1;
        @(negedge clk);
        rdata = rsp.prdata;
        @(posedge clk);
        #2;
        req = '0;
    endtask

    task automatic run_fma(input logic [15:0] x, input logic [15:0] y, input logic [15:0] z);
        apb_transfer(1'b1, REG_X, {16'd0, x});
        apb_transfer(1'b1, REG_Y, {16'd0, y});
        apb_transfer(1'b1, REG_Z, {16'd0, z});
        apb_transfer(1'b1, REG_CTRL, 32'd1);
        rdata = '0;
        while (!rdata[STAT_DONE]) apb_transfer(1'b0, REG_STATUS, '0);
        apb_transfer(1'b0, REG_RESULT, '0);
    endtask

    // a normal number near one in magnitude, or a signed zero one time in eight
    function automatic logic [15:0] random_half();
        logic [4:0] e;
        e = ($urandom_range(7, 0) == 0) ? 5'd0 : 5'($urandom_range(26, 4));
        if (e == 5'd0) return {1'($urandom), 15'd0};
        return {1'($urandom), e, 10'($urandom)};
    endfunction

    initial begin
        void'($urandom(60627));
        req = '0;
        rst = 1'b1;
        test_id = 1;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        // every offset reads zero after reset and 0x18 is out of the map
        for (int a = 0; a <= 8'h18; a += 4) apb_transfer(1'b0, 8'(a), '0);
        apb_transfer(1'b1, REG_X, 32'hABCD_1234);
        apb_transfer(1'b1, REG_Y, 32'h0000_5A5A);
        apb_transfer(1'b1, REG_Z, 32'h0000_C3C3);
        apb_transfer(1'b1, REG_RESULT, 32'h1);
        apb_transfer(1'b1, REG_STATUS, 32'h7);
        apb_transfer(1'b1, 8'h20, 32'h1);
        apb_transfer(1'b0, 8'h03, '0);
        for (int a = 0; a < 8'h18; a += 4) apb_transfer(1'b0, 8'(a), '0);
        test_id = 2;
        run_fma(16'h4000, 16'h4200, 16'h3C00);
        run_fma(16'h3800, 16'h4400, 16'h3400);
        run_fma(16'h3E00, 16'h3E00, 16'h0000);
        run_fma(16'h0000, 16'h4500, 16'hC200);
        // exact and near cancellation keep the exponents close
        test_id = 3;
        run_fma(16'h4200, 16'h4500, 16'hCB80);
        run_fma(16'h3C01, 16'h3C01, 16'hBC00);
        run_fma(16'h3C01, 16'h3BFF, 16'hBC00);
        run_fma(16'h4247, 16'hC155, 16'h47D9);
        test_id = 4;
        run_fma(16'h3C00, 16'h1400, 16'h6400);
        run_fma(16'h3800, 16'h3C00, 16'h6400);
        run_fma(16'h3800, 16'h3C00, 16'h6401);
        run_fma(16'hB400, 16'h3C00, 16'h6400);
        run_fma(16'hB800, 16'h3C00, 16'h6400);
        run_fma(16'h6400, 16'h3C00, 16'h0400);
        run_fma(16'h6400, 16'h3C00, 16'h8400);
        run_fma(16'h1400, 16'h1400, 16'hBC00);
        test_id = 5;
        run_fma(16'h7800, 16'h4000, 16'h0000);
        run_fma(16'hF800, 16'h4000, 16'h3C00);
        run_fma(16'h7BFF, 16'h3C00, 16'h5000);
        run_fma(16'h0400, 16'h3800, 16'h0000);
        run_fma(16'h8400, 16'h3800, 16'h0000);
        run_fma(16'h0401, 16'h3C00, 16'h8400);
        test_id = 6;
        repeat (NUM_RANDOM) run_fma(random_half(), random_half(), random_half());
        repeat (2) @(posedge clk);
        $display("fma16 run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the test sequence did not complete", cycles);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== fma16_apb.f ====
verilog/fma16_pkg.sv
verilog/fma16_apb_pkg.sv
verilog/fma16_align.sv
verilog/fma16_mshifter.sv
verilog/fma16_normround.sv
verilog/fma16_regs.sv
verilog/fma16_apb.sv
test/fma16_checker.sv
test/tb_fma16.sv

// ==== Bender.yml ====
package:
  name: fma16_apb

sources:
  - verilog/fma16_pkg.sv
  - verilog/fma16_apb_pkg.sv
  - verilog/fma16_align.sv
  - verilog/fma16_mshifter.sv
  - verilog/fma16_normround.sv
  - verilog/fma16_regs.sv
  - verilog/fma16_apb.sv
  - target: test
    files:
      - test/fma16_checker.sv
      - test/tb_fma16.sv
